/* net_rd_pkg.sv */
package net_rd_pkg;

    // ----------------------------
    // Sizes
    // ----------------------------
    // Memory regions behind the mux
    localparam int n_regions     = 3;
    localparam int region_bits   = 2;

    // Data beat and byte enables
    localparam int data_bits     = 64;
    localparam int keep_bits     = data_bits / 8;
    localparam int beat_log_bits = $clog2(keep_bits);

    // Request fields
    localparam int len_bits      = 12;
    localparam int vaddr_bits    = 32;
    // One extra bit so a full-length beat count fits
    localparam int beat_cnt_bits = len_bits - beat_log_bits + 1;

    // Queue depths
    localparam int req_fifo_depth  = 4;
    localparam int seq_fifo_depth  = 8;
    localparam int data_fifo_depth = 16;

    // ----------------------------
    // Types
    // ----------------------------
    // Read request as seen on the command port
    typedef struct packed {
        logic [region_bits-1:0] region;
        logic                   host;
        logic [vaddr_bits-1:0]  vaddr;
        logic [len_bits-1:0]    len;
    } rd_req_t;

    // In-order record of an accepted request
    typedef struct packed {
        logic [region_bits-1:0] region;
        logic [len_bits-1:0]    len;
    } seq_entry_t;

    // Data mux FSM
    typedef enum logic [0:0] {st_idle, st_mux} mux_state_t;

endpackage

/* rd_req_if.sv */
`timescale 1ns/1ps

interface rd_req_if;

    import net_rd_pkg::*;

    // Request handshake
    logic    valid;
    logic    ready;
    // Request payload, stable while valid and not ready
    rd_req_t req;

    // Producer side
    modport src (
        output valid,
        output req,
        input  ready
    );

    // Consumer side
    modport snk (
        input  valid,
        input  req,
        output ready
    );

endinterface

/* rd_stream_if.sv */
`timescale 1ns/1ps

interface rd_stream_if;

    import net_rd_pkg::*;

    // Beat handshake
    logic                 tvalid;
    logic                 tready;
    // Beat payload
    logic [data_bits-1:0] tdata;
    logic [keep_bits-1:0] tkeep;
    // Set on the final beat of a response
    logic                 tlast;

    // Producer side
    modport src (
        output tvalid,
        output tdata,
        output tkeep,
        output tlast,
        input  tready
    );

    // Consumer side
    modport snk (
        input  tvalid,
        input  tdata,
        input  tkeep,
        input  tlast,
        output tready
    );

endinterface

/* sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter int  depth  = 4,
    parameter type t_data = logic [7:0]
) (
    input  logic  aclk,
    input  logic  aresetn,

    input  logic  in_valid,
    output logic  in_ready,
    input  t_data in_data,

    output logic  out_valid,
    input  logic  out_ready,
    output t_data out_data
);

    // Storage, payload only
    t_data mem [depth];

    // Circular pointers and occupancy
    logic [$clog2(depth)-1:0]   wr_ptr;
    logic [$clog2(depth)-1:0]   rd_ptr;
    logic [$clog2(depth+1)-1:0] count;

    logic push;
    logic pop;

    // ----------------------------
    // Handshake
    // ----------------------------
    // Room whenever not full, independent of the pop side
    assign in_ready  = (count != depth);
    assign out_valid = (count != 0);
    assign push      = in_valid & in_ready;
    assign pop       = out_valid & out_ready;

    // Head shown directly, no read bubble
    assign out_data = mem[rd_ptr];

    // ----------------------------
    // Storage write
    // ----------------------------
    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // ----------------------------
    // Pointers and count
    // ----------------------------
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Wrap at depth, not only at a power of two
            if (push) begin
                wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Full queue has its write pointer wrapped onto the head
    a_full_ptrs: assert property (@(posedge aclk) disable iff (!aresetn)
        (count == depth) |-> (wr_ptr == rd_ptr));

    // Empty queue has both pointers together
    a_empty_ptrs: assert property (@(posedge aclk) disable iff (!aresetn)
        (count == 0) |-> (wr_ptr == rd_ptr));

endmodule

/* cmd_dispatch.sv */
`timescale 1ns/1ps

module cmd_dispatch (
    input  logic                   aclk,
    input  logic                   aresetn,

    rd_req_if.snk                  req_in,
    rd_req_if.src                  reg_req [net_rd_pkg::n_regions],

    output logic                   seq_valid,
    input  logic                   seq_ready,
    output net_rd_pkg::seq_entry_t seq_entry
);

    import net_rd_pkg::*;

    // Room in each region request queue
    logic [n_regions-1:0] reg_room;
    // Push strobe per region queue
    logic [n_regions-1:0] reg_push;

    // Sequence queue room and push
    logic       seq_room;
    logic       seq_push;
    // Room of the queue the request targets
    logic       sel_room;
    seq_entry_t seq_in;

    // ----------------------------
    // Decode and accept
    // ----------------------------
    // Pick the room flag of the addressed region
    always_comb begin
        // Unknown region has no queue to wait on
        sel_room = 1'b1;
        for (int i = 0; i < n_regions; i++) begin
            if (req_in.req.region == i) begin
                sel_room = reg_room[i];
            end
        end
    end

    // Host requests need both queues, card requests only the sequence queue
    assign req_in.ready = seq_room & (req_in.req.host ? sel_room : 1'b1);
    assign seq_push     = req_in.valid & req_in.ready;

    // Sequence record keeps region and length only
    assign seq_in.region = req_in.req.region;
    assign seq_in.len    = req_in.req.len;

    // ----------------------------
    // Region request queues
    // ----------------------------
    for (genvar i = 0; i < n_regions; i++) begin : g_reg_que
        // Forward only host requests, only to their own region
        assign reg_push[i] = seq_push & req_in.req.host & (req_in.req.region == i);

        sync_fifo #(
            .depth  (req_fifo_depth),
            .t_data (rd_req_t)
        ) u_req_fifo (
            .aclk      (aclk),
            .aresetn   (aresetn),
            .in_valid  (reg_push[i]),
            .in_ready  (reg_room[i]),
            .in_data   (req_in.req),
            .out_valid (reg_req[i].valid),
            .out_ready (reg_req[i].ready),
            .out_data  (reg_req[i].req)
        );
    end

    // ----------------------------
    // Sequence queue
    // ----------------------------
    // Entries in acceptance order, drained by the data mux
    sync_fifo #(
        .depth  (seq_fifo_depth),
        .t_data (seq_entry_t)
    ) u_seq_fifo (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_valid  (seq_push),
        .in_ready  (seq_room),
        .in_data   (seq_in),
        .out_valid (seq_valid),
        .out_ready (seq_ready),
        .out_data  (seq_entry)
    );

    // Accepted requests must name a real region and carry data
    a_req_legal: assert property (@(posedge aclk) disable iff (!aresetn)
        req_in.valid && req_in.ready |->
            (req_in.req.len != 0) && (req_in.req.region < n_regions));

endmodule

/* rd_data_mux.sv */
`timescale 1ns/1ps

module rd_data_mux (
    input  logic                   aclk,
    input  logic                   aresetn,

    input  logic                   seq_valid,
    output logic                   seq_ready,
    input  net_rd_pkg::seq_entry_t seq_entry,

    rd_stream_if.snk               reg_data [net_rd_pkg::n_regions],
    rd_stream_if.src               out_data
);

    import net_rd_pkg::*;

    // FSM
    mux_state_t state_q;
    mux_state_t state_d;

    // Region being drained
    logic [region_bits-1:0]   region_q;
    // Beat index within the response
    logic [beat_cnt_bits-1:0] cnt_q;
    // Index of the final beat
    logic [beat_cnt_bits-1:0] last_q;

    // Buffer heads flattened from the interface array
    logic [n_regions-1:0]                reg_tvalid;
    logic [n_regions-1:0][data_bits-1:0] reg_tdata;
    logic [n_regions-1:0][keep_bits-1:0] reg_tkeep;
    logic [n_regions-1:0]                reg_tlast;

    // Selected head
    logic                 sel_tvalid;
    logic [data_bits-1:0] sel_tdata;
    logic [keep_bits-1:0] sel_tkeep;
    logic                 sel_tlast;

    logic beat_fire;
    logic last_fire;
    logic seq_load;

    // Whole beats when partial, one less when exact
    function automatic logic [beat_cnt_bits-1:0] last_index(input logic [len_bits-1:0] len);
        logic [beat_cnt_bits-1:0] beats;
        beats = beat_cnt_bits'(len[len_bits-1:beat_log_bits]);
        return (len[beat_log_bits-1:0] != '0) ? beats : beats - 1'b1;
    endfunction

    // ----------------------------
    // Region select
    // ----------------------------
    for (genvar i = 0; i < n_regions; i++) begin : g_reg
        assign reg_tvalid[i] = reg_data[i].tvalid;
        assign reg_tdata[i]  = reg_data[i].tdata;
        assign reg_tkeep[i]  = reg_data[i].tkeep;
        assign reg_tlast[i]  = reg_data[i].tlast;
        // Other buffers hold their heads
        assign reg_data[i].tready = (state_q == st_mux) && (region_q == i) && out_data.tready;
    end

    always_comb begin
        sel_tvalid = 1'b0;
        sel_tdata  = '0;
        sel_tkeep  = '0;
        sel_tlast  = 1'b0;
        for (int i = 0; i < n_regions; i++) begin
            if (region_q == i) begin
                sel_tvalid = reg_tvalid[i];
                sel_tdata  = reg_tdata[i];
                sel_tkeep  = reg_tkeep[i];
                sel_tlast  = reg_tlast[i];
            end
        end
    end

    // Output straight from the buffer head, tlast passed through
    assign out_data.tvalid = (state_q == st_mux) & sel_tvalid;
    assign out_data.tdata  = sel_tdata;
    assign out_data.tkeep  = sel_tkeep;
    assign out_data.tlast  = sel_tlast;

    assign beat_fire = out_data.tvalid & out_data.tready;
    assign last_fire = beat_fire & (cnt_q == last_q);

    // ----------------------------
    // Sequence pop and next state
    // ----------------------------
    // Idle pops at once, busy pops on the final beat
    assign seq_ready = (state_q == st_idle) | last_fire;
    assign seq_load  = seq_valid & seq_ready;

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (seq_load) begin
                    state_d = st_mux;
                end
            end
            st_mux: begin
                // Back to back responses stay in st_mux
                if (last_fire && !seq_valid) begin
                    state_d = st_idle;
                end
            end
            default: state_d = st_idle;
        endcase
    end

    // ----------------------------
    // Registers
    // ----------------------------
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state_q  <= st_idle;
            region_q <= '0;
            cnt_q    <= '0;
            last_q   <= '0;
        end else begin
            state_q <= state_d;
            if (seq_load) begin
                region_q <= seq_entry.region;
                cnt_q    <= '0;
                last_q   <= last_index(seq_entry.len);
            end else if (beat_fire) begin
                // Frozen while out_tready is low
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // Beat counter never runs past the final beat of the loaded entry
    a_cnt_bound: assert property (@(posedge aclk) disable iff (!aresetn)
        beat_fire |-> (cnt_q <= last_q));

    // Region tlast must agree with the counted final beat
    a_tlast_count: assert property (@(posedge aclk) disable iff (!aresetn)
        beat_fire |-> (out_data.tlast == (cnt_q == last_q)));

endmodule

/* net_rd_mux_top.sv */
`timescale 1ns/1ps

module net_rd_mux_top (
    input  logic                                                       aclk,
    input  logic                                                       aresetn,

    // Command port
    input  logic                                                       req_valid,
    output logic                                                       req_ready,
    input  logic [net_rd_pkg::region_bits-1:0]                         req_region,
    input  logic                                                       req_host,
    input  logic [net_rd_pkg::vaddr_bits-1:0]                          req_vaddr,
    input  logic [net_rd_pkg::len_bits-1:0]                            req_len,

    // Region request ports
    output logic [net_rd_pkg::n_regions-1:0]                           reg_req_valid,
    input  logic [net_rd_pkg::n_regions-1:0]                           reg_req_ready,
    output logic [net_rd_pkg::n_regions-1:0][net_rd_pkg::vaddr_bits-1:0] reg_req_vaddr,
    output logic [net_rd_pkg::n_regions-1:0][net_rd_pkg::len_bits-1:0] reg_req_len,

    // Region read data
    input  logic [net_rd_pkg::n_regions-1:0]                           rd_data_valid,
    output logic [net_rd_pkg::n_regions-1:0]                           rd_data_ready,
    input  logic [net_rd_pkg::n_regions-1:0][net_rd_pkg::data_bits-1:0] rd_data_data,
    input  logic [net_rd_pkg::n_regions-1:0][net_rd_pkg::keep_bits-1:0] rd_data_keep,
    input  logic [net_rd_pkg::n_regions-1:0]                           rd_data_last,

    // Merged output stream
    output logic                                                       out_tvalid,
    input  logic                                                       out_tready,
    output logic [net_rd_pkg::data_bits-1:0]                           out_tdata,
    output logic [net_rd_pkg::keep_bits-1:0]                           out_tkeep,
    output logic                                                       out_tlast
);

    import net_rd_pkg::*;

    rd_req_if    req_in_if ();
    rd_req_if    reg_req_if [n_regions] ();
    rd_stream_if rd_in_if [n_regions] ();
    rd_stream_if rd_buf_if [n_regions] ();
    rd_stream_if out_if ();

    // Sequence stream between dispatch and mux
    logic       seq_valid;
    logic       seq_ready;
    seq_entry_t seq_entry;

    // Packed beats through the data buffers
    logic [n_regions-1:0][data_bits+keep_bits:0] in_beat;
    logic [n_regions-1:0][data_bits+keep_bits:0] out_beat;

    // ----------------------------
    // Command side
    // ----------------------------
    assign req_in_if.valid = req_valid;
    assign req_in_if.req   = '{region: req_region, host: req_host, vaddr: req_vaddr, len: req_len};
    assign req_ready       = req_in_if.ready;

    cmd_dispatch u_dispatch (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .req_in    (req_in_if),
        .reg_req   (reg_req_if),
        .seq_valid (seq_valid),
        .seq_ready (seq_ready),
        .seq_entry (seq_entry)
    );

    // ----------------------------
    // Region data buffers
    // ----------------------------
    for (genvar i = 0; i < n_regions; i++) begin : g_region
        // Region request queue heads to plain ports
        assign reg_req_valid[i]    = reg_req_if[i].valid;
        assign reg_req_vaddr[i]    = reg_req_if[i].req.vaddr;
        assign reg_req_len[i]      = reg_req_if[i].req.len;
        assign reg_req_if[i].ready = reg_req_ready[i];

        assign rd_in_if[i].tvalid = rd_data_valid[i];
        assign rd_in_if[i].tdata  = rd_data_data[i];
        assign rd_in_if[i].tkeep  = rd_data_keep[i];
        assign rd_in_if[i].tlast  = rd_data_last[i];
        assign rd_data_ready[i]   = rd_in_if[i].tready;

        // Beat packed as data, keep, last
        assign in_beat[i] = {rd_in_if[i].tdata, rd_in_if[i].tkeep, rd_in_if[i].tlast};
        assign rd_buf_if[i].tdata = out_beat[i][data_bits+keep_bits:keep_bits+1];
        assign rd_buf_if[i].tkeep = out_beat[i][keep_bits:1];
        assign rd_buf_if[i].tlast = out_beat[i][0];

        sync_fifo #(
            .depth  (data_fifo_depth),
            .t_data (logic [data_bits+keep_bits:0])
        ) u_data_fifo (
            .aclk      (aclk),
            .aresetn   (aresetn),
            .in_valid  (rd_in_if[i].tvalid),
            .in_ready  (rd_in_if[i].tready),
            .in_data   (in_beat[i]),
            .out_valid (rd_buf_if[i].tvalid),
            .out_ready (rd_buf_if[i].tready),
            .out_data  (out_beat[i])
        );
    end

    // ----------------------------
    // Data mux and output
    // ----------------------------
    rd_data_mux u_data_mux (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .seq_valid (seq_valid),
        .seq_ready (seq_ready),
        .seq_entry (seq_entry),
        .reg_data  (rd_buf_if),
        .out_data  (out_if)
    );

    assign out_tvalid    = out_if.tvalid;
    assign out_tdata     = out_if.tdata;
    assign out_tkeep     = out_if.tkeep;
    assign out_tlast     = out_if.tlast;
    assign out_if.tready = out_tready;

endmodule

/* tb_net_rd_mux.sv */
`timescale 1ns/1ps

module tb_net_rd_mux;

    import net_rd_pkg::*;

    localparam int max_tests  = 32;
    localparam int wait_limit = 2000;

    logic                                 aclk;
    logic                                 aresetn;
    logic                                 req_valid;
    logic                                 req_ready;
    logic [region_bits-1:0]               req_region;
    logic                                 req_host;
    logic [vaddr_bits-1:0]                req_vaddr;
    logic [len_bits-1:0]                  req_len;
    logic [n_regions-1:0]                 reg_req_valid;
    logic [n_regions-1:0]                 reg_req_ready;
    logic [n_regions-1:0][vaddr_bits-1:0] reg_req_vaddr;
    logic [n_regions-1:0][len_bits-1:0]   reg_req_len;
    logic [n_regions-1:0]                 rd_data_valid;
    logic [n_regions-1:0]                 rd_data_ready;
    logic [n_regions-1:0][data_bits-1:0]  rd_data_data;
    logic [n_regions-1:0][keep_bits-1:0]  rd_data_keep;
    logic [n_regions-1:0]                 rd_data_last;
    logic                                 out_tvalid;
    logic                                 out_tready;
    logic [data_bits-1:0]                 out_tdata;
    logic [keep_bits-1:0]                 out_tkeep;
    logic                                 out_tlast;

    // Five words per request: region, host, vaddr, len, tag
    logic [31:0] tests [5*max_tests];
    int          n_tests;
    int          n_accepted;
    bit          saw_full;
    bit          run_done;
    // Region request seen on its port
    bit          served [max_tests];
    // Host request indices per region, file order
    int          host_idx [n_regions][max_tests];
    int          host_cnt [n_regions];
    int          host_pos [n_regions];
    logic [31:0] rng;

    net_rd_mux_top u_dut (.*);

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] field(input int i, input int f);
        return tests[5*i + f];
    endfunction

    // ceil(len/8)
    function automatic int beat_count(input int len);
        return (len + 7) / 8;
    endfunction

    // Partial keep only on the last beat of a ragged length
    function automatic logic [7:0] beat_keep(input int len, input int k);
        if (k == beat_count(len) - 1 && (len % 8) != 0) begin
            return 8'hff >> (8 - len % 8);
        end
        return 8'hff;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s at %0t ns", msg, $time);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic value_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
        $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        $display("Errors found");
        $fatal(1);
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    // Random back-pressure on region requests and output
    task automatic drive_ready();
        while (!run_done) begin
            rng           = xorshift32(rng);
            reg_req_ready = rng[2:0];
            out_tready    = rng[8];
            @(posedge aclk);
            #1;
        end
    endtask

    task automatic drive_requests();
        int waited;
        for (int i = 0; i < n_tests; i++) begin
            req_valid  = 1'b1;
            req_region = region_bits'(field(i, 0));
            req_host   = field(i, 1) != 0;
            req_vaddr  = field(i, 2);
            req_len    = len_bits'(field(i, 3));
            waited     = 0;
            do begin
                @(posedge aclk);
                waited++;
                // Queue full seen as back-pressure
                if (!req_ready) saw_full = 1'b1;
                assert (waited < wait_limit) else abort_run("Timeout waiting for req_ready");
            end while (!req_ready);
            n_accepted++;
            #1;
        end
        req_valid = 1'b0;
    endtask

    // Region models, responses served in file order
    task automatic return_data();
        int waited;
        int r;
        int len;
        for (int i = 0; i < n_tests; i++) begin
            r      = field(i, 0);
            len    = field(i, 3);
            waited = 0;
            // Data only after acceptance, host reads also after the region request
            while (n_accepted <= i || (field(i, 1) != 0 && !served[i])) begin
                @(posedge aclk);
                #1;
                waited++;
                assert (waited < wait_limit) else abort_run("Timeout waiting for a request");
            end
            for (int k = 0; k < beat_count(len); k++) begin
                rd_data_valid[r] = 1'b1;
                rd_data_data[r]  = {field(i, 4), 32'(k)};
                rd_data_keep[r]  = beat_keep(len, k);
                rd_data_last[r]  = (k == beat_count(len) - 1);
                waited = 0;
                do begin
                    @(posedge aclk);
                    waited++;
                    assert (waited < wait_limit) else abort_run("Timeout waiting for rd_data_ready");
                end while (!rd_data_ready[r]);
                #1;
            end
            rd_data_valid[r] = 1'b0;
        end
    endtask

    // ------------------------------
    // Checkers
    // ------------------------------
    task automatic watch_region_requests();
        int idx;
        while (!run_done) begin
            @(posedge aclk);
            for (int r = 0; r < n_regions; r++) begin
                if (reg_req_valid[r] && reg_req_ready[r]) begin
                    assert (host_pos[r] < host_cnt[r])
                        else abort_run("Unexpected request on a region request port");
                    idx = host_idx[r][host_pos[r]];
                    host_pos[r]++;
                    served[idx] = 1'b1;
                    assert (reg_req_vaddr[r] == field(idx, 2))
                        else value_mismatch("reg_req_vaddr", reg_req_vaddr[r], field(idx, 2));
                    assert (reg_req_len[r] == field(idx, 3))
                        else value_mismatch("reg_req_len", reg_req_len[r], field(idx, 3));
                end
            end
        end
    endtask

    // Every beat in file order, tlast on the counted final beat
    task automatic check_output();
        int          waited;
        int          len;
        logic [63:0] exp_data;
        for (int i = 0; i < n_tests; i++) begin
            len = field(i, 3);
            for (int k = 0; k < beat_count(len); k++) begin
                exp_data = {field(i, 4), 32'(k)};
                waited   = 0;
                do begin
                    @(posedge aclk);
                    waited++;
                    assert (waited < wait_limit) else abort_run("Timeout waiting for an output beat");
                end while (!(out_tvalid && out_tready));
                assert (out_tdata == exp_data)
                    else value_mismatch("out_tdata", out_tdata, exp_data);
                assert (out_tkeep == beat_keep(len, k))
                    else value_mismatch("out_tkeep", out_tkeep, beat_keep(len, k));
                assert (out_tlast == (k == beat_count(len) - 1))
                    else value_mismatch("out_tlast", out_tlast, k == beat_count(len) - 1);
            end
        end
    endtask

    initial begin
        int r;
        aresetn       = 1'b0;
        req_valid     = 1'b0;
        req_region    = '0;
        req_host      = 1'b0;
        req_vaddr     = '0;
        req_len       = '0;
        reg_req_ready = '0;
        rd_data_valid = '0;
        rd_data_data  = '0;
        rd_data_keep  = '0;
        rd_data_last  = '0;
        out_tready    = 1'b0;
        n_tests       = 0;
        n_accepted    = 0;
        saw_full      = 1'b0;
        run_done      = 1'b0;
        rng           = 32'h9433981b;
        host_cnt      = '{default: 0};
        host_pos      = '{default: 0};
        tests         = '{default: '0};
        $readmemh("net_rd_tests.txt", tests);
        // Table ends at the first entry with zero length
        while (n_tests < max_tests && field(n_tests, 3) != 0) begin
            if (field(n_tests, 1) != 0) begin
                r = field(n_tests, 0);
                host_idx[r][host_cnt[r]] = n_tests;
                host_cnt[r]++;
            end
            n_tests++;
        end
        assert (n_tests > 0) else abort_run("No requests read from net_rd_tests.txt");

        repeat (3) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        assert (out_tvalid == 1'b0) else value_mismatch("out_tvalid", out_tvalid, 0);
        assert (reg_req_valid == '0) else value_mismatch("reg_req_valid", reg_req_valid, 0);
        assert (req_ready == 1'b1) else value_mismatch("req_ready", req_ready, 1);
        // Empty data buffers accept at once
        assert (rd_data_ready == '1)
            else value_mismatch("rd_data_ready", rd_data_ready, (1 << n_regions) - 1);

        fork
            drive_ready();
            watch_region_requests();
        join_none
        fork
            drive_requests();
            return_data();
            check_output();
        join

        // Idle window, nothing more may come out
        repeat (50) begin
            @(posedge aclk);
            assert (!out_tvalid) else abort_run("Output beat after the last expected response");
        end
        for (int k = 0; k < n_regions; k++) begin
            assert (host_pos[k] == host_cnt[k])
                else abort_run("A host request never reached its region");
        end
        assert (saw_full) else abort_run("req_ready never dropped, request queues never filled");
        run_done = 1'b1;
        $display("No errors");
        $finish;
    end

endmodule

/* net_rd_tests.txt */
// Read requests, one per line, all values in hex
// region host vaddr len tag
0 1 10000000 008 a0000000
1 1 20000040 001 a0000001
2 0 30000000 010 a0000002
0 0 10001000 00d a0000003
1 1 20000100 040 a0000004
2 1 30000200 003 a0000005
0 1 10000200 018 a0000006
1 0 20002000 007 a0000007
2 1 30000400 021 a0000008
0 1 10000400 001 a0000009
1 1 20000800 030 a000000a
2 0 30004000 020 a000000b
0 1 10000800 05f a000000c
1 1 20000c00 009 a000000d
2 1 30000800 011 a000000e
0 0 10008000 028 a000000f
1 1 20001000 002 a0000010
2 1 30000c00 038 a0000011
0 1 10000c00 00f a0000012
1 0 20004000 008 a0000013
2 1 30001000 001 a0000014
0 1 10001000 048 a0000015
1 1 20001400 019 a0000016
2 0 30008000 006 a0000017
0 1 10001400 010 a0000018
1 1 20001800 027 a0000019
2 1 30001400 00c a000001a
0 0 1000c000 004 a000001b

/* compile.f */
net_rd_pkg.sv
rd_req_if.sv
rd_stream_if.sv
sync_fifo.sv
cmd_dispatch.sv
rd_data_mux.sv
net_rd_mux_top.sv
tb_net_rd_mux.sv
